// File: Makefile
SRCS := $(shell cat project.f)

obj_dir/Vtb_mcu_cmd: project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mcu_cmd -f project.f

run: obj_dir/Vtb_mcu_cmd
	./obj_dir/Vtb_mcu_cmd > sim.log 2>&1
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: cart_config_regs.sv
`timescale 1ns/1ps

module cart_config_regs (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cmd_ready,
  input  logic                     param_ready,
  input  cmd_proto_pkg::spi_byte_t cmd_data,
  input  cmd_proto_pkg::spi_byte_t param_data,
  input  cmd_proto_pkg::byte_cnt_t spi_byte_cnt,
  output cart_mem_pkg::mapper_t    mcu_mapper,
  output cart_mem_pkg::cart_mask_t rom_mask_out,
  output cart_mem_pkg::cart_mask_t saveram_mask_out,
  output cart_mem_pkg::feature_t   featurebits_out
);

  import cmd_proto_pkg::*;
  import cart_mem_pkg::*;

  // upper feature byte until the lower one arrives
  spi_byte_t feat_hi;

  // masks arrive big-endian, one byte per parameter
  function automatic cart_mask_t mask_update(
    input cart_mask_t cur,
    input byte_cnt_t  cnt,
    input spi_byte_t  b
  );
    cart_mask_t nxt;
    nxt = cur;
    case (cnt)
      CNT_P1:  nxt[23:16] = b;
      CNT_P2:  nxt[15:8]  = b;
      CNT_P3:  nxt[7:0]   = b;
      default: nxt = cur;
    endcase
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // mapper and address masks
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcu_mapper       <= '0;
      rom_mask_out     <= '0;
      saveram_mask_out <= '0;
    end else if (cmd_ready) begin
      // mapper comes in the command byte itself
      if (cmd_data[7:4] == OP_MAPPER_HI) begin
        mcu_mapper <= cmd_data[3:0];
      end
    end else if (param_ready) begin
      if (cmd_data[7:4] == OP_ROM_MASK_HI) begin
        rom_mask_out <= mask_update(rom_mask_out, spi_byte_cnt, param_data);
      end
      if (cmd_data[7:4] == OP_SRAM_MASK_HI) begin
        saveram_mask_out <= mask_update(saveram_mask_out, spi_byte_cnt, param_data);
      end
    end
  end

  //////////////////////////////////////////////////
  // feature word
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (param_ready && cmd_data == OP_FEATURE && spi_byte_cnt == CNT_P1) begin
      feat_hi <= param_data;
    end
  end

  // whole word updates at once on the second byte
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      featurebits_out <= '0;
    end else if (param_ready && cmd_data == OP_FEATURE && spi_byte_cnt == CNT_P2) begin
      featurebits_out <= {feat_hi, param_data};
    end
  end

endmodule

// File: cart_mem_pkg.sv
package cart_mem_pkg;

  //////////////////////////////////////////////////
  // cartridge memory side types
  //////////////////////////////////////////////////

  // width of the cartridge address bus
  localparam int CART_AW = 24;

  // byte address into ROM / save RAM
  typedef logic [CART_AW-1:0] cart_addr_t;

  // address mask, same width as the address
  typedef logic [CART_AW-1:0] cart_mask_t;

  // mapper selection from the 0x3n command
  typedef logic [3:0] mapper_t;

  // feature enable bits
  typedef logic [15:0] feature_t;

endpackage

// File: cmd_proto_pkg.sv
package cmd_proto_pkg;

  //////////////////////////////////////////////////
  // serial link data types
  //////////////////////////////////////////////////

  // one byte as shifted over the link
  typedef logic [7:0]  spi_byte_t;

  // running byte count, command byte is count 1
  typedef logic [31:0] byte_cnt_t;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////

  // high nibble matches
  localparam logic [3:0] OP_ADDR_HI         = 4'h0;
  localparam logic [3:0] OP_ROM_MASK_HI     = 4'h1;
  localparam logic [3:0] OP_SRAM_MASK_HI    = 4'h2;
  localparam logic [3:0] OP_MAPPER_HI       = 4'h3;
  localparam logic [3:0] OP_MEM_READ_HI     = 4'h8;
  localparam logic [3:0] OP_MEM_WRITE_HI    = 4'h9;
  localparam logic [3:0] OP_SNESCMD_READ_HI = 4'hA;

  // full byte matches
  localparam spi_byte_t OP_SNESCMD_SETADDR  = 8'hD0;
  localparam spi_byte_t OP_SNESCMD_READNEXT = 8'hD1;
  localparam spi_byte_t OP_SNESCMD_WRITE    = 8'hD2;
  localparam spi_byte_t OP_FEATURE          = 8'hED;
  localparam spi_byte_t OP_SIGNATURE        = 8'hF0;
  localparam spi_byte_t OP_ECHO             = 8'hFF;

  // byte positions within a transaction
  localparam byte_cnt_t CNT_CMD = 32'd1;
  localparam byte_cnt_t CNT_P1  = 32'd2;
  localparam byte_cnt_t CNT_P2  = 32'd3;
  localparam byte_cnt_t CNT_P3  = 32'd4;

endpackage

// File: mcu_cmd_top.sv
`timescale 1ns/1ps

module mcu_cmd_top #(
  parameter cmd_proto_pkg::spi_byte_t SIG_BYTE   = 8'hA5,
  parameter int                       SNESCMD_AW = 9
) (
  input  logic                     clk,
  input  logic                     arst_n,
  // serial link
  input  logic                     cmd_ready,
  input  logic                     param_ready,
  input  cmd_proto_pkg::spi_byte_t cmd_data,
  input  cmd_proto_pkg::spi_byte_t param_data,
  input  cmd_proto_pkg::byte_cnt_t spi_byte_cnt,
  output cmd_proto_pkg::spi_byte_t spi_data_out,
  // cartridge configuration
  output cart_mem_pkg::mapper_t    mcu_mapper,
  output cart_mem_pkg::cart_mask_t rom_mask_out,
  output cart_mem_pkg::cart_mask_t saveram_mask_out,
  output cart_mem_pkg::feature_t   featurebits_out,
  // memory access
  output logic                     mcu_rrq,
  output logic                     mcu_wrq,
  input  logic                     mcu_rq_rdy,
  output cmd_proto_pkg::spi_byte_t mcu_data_out,
  input  cmd_proto_pkg::spi_byte_t mcu_data_in,
  output cart_mem_pkg::cart_addr_t addr_out,
  // console command RAM
  input  cmd_proto_pkg::spi_byte_t snescmd_data_in,
  output logic [SNESCMD_AW-1:0]    snescmd_addr_out,
  output cmd_proto_pkg::spi_byte_t snescmd_data_out,
  output logic                     snescmd_we_out
);

  // read data valid strobe
  logic mem_data_capture;

  cart_config_regs cfg_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .cmd_ready        (cmd_ready),
    .param_ready      (param_ready),
    .cmd_data         (cmd_data),
    .param_data       (param_data),
    .spi_byte_cnt     (spi_byte_cnt),
    .mcu_mapper       (mcu_mapper),
    .rom_mask_out     (rom_mask_out),
    .saveram_mask_out (saveram_mask_out),
    .featurebits_out  (featurebits_out)
  );

  mcu_mem_access mem_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .cmd_ready        (cmd_ready),
    .param_ready      (param_ready),
    .cmd_data         (cmd_data),
    .param_data       (param_data),
    .spi_byte_cnt     (spi_byte_cnt),
    .mcu_rq_rdy       (mcu_rq_rdy),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .mcu_data_out     (mcu_data_out),
    .addr_out         (addr_out),
    .mem_data_capture (mem_data_capture)
  );

  snescmd_port #(
    .SNESCMD_AW (SNESCMD_AW)
  ) snescmd_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .param_ready      (param_ready),
    .cmd_data         (cmd_data),
    .param_data       (param_data),
    .spi_byte_cnt     (spi_byte_cnt),
    .snescmd_addr_out (snescmd_addr_out),
    .snescmd_data_out (snescmd_data_out),
    .snescmd_we_out   (snescmd_we_out)
  );

  mcu_response #(
    .SIG_BYTE (SIG_BYTE)
  ) resp_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .cmd_ready        (cmd_ready),
    .param_ready      (param_ready),
    .cmd_data         (cmd_data),
    .param_data       (param_data),
    .mem_data_capture (mem_data_capture),
    .mcu_data_in      (mcu_data_in),
    .snescmd_data_in  (snescmd_data_in),
    .spi_data_out     (spi_data_out)
  );

endmodule

// File: mcu_mem_access.sv
`timescale 1ns/1ps

module mcu_mem_access (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cmd_ready,
  input  logic                     param_ready,
  input  cmd_proto_pkg::spi_byte_t cmd_data,
  input  cmd_proto_pkg::spi_byte_t param_data,
  input  cmd_proto_pkg::byte_cnt_t spi_byte_cnt,
  input  logic                     mcu_rq_rdy,
  output logic                     mcu_rrq,
  output logic                     mcu_wrq,
  output cmd_proto_pkg::spi_byte_t mcu_data_out,
  output cart_mem_pkg::cart_addr_t addr_out,
  output logic                     mem_data_capture
);

  import cmd_proto_pkg::*;

  logic [3:0] cmd_hi;
  logic       is_read;
  logic       is_write;
  logic       addr_load;
  logic       addr_incr;

  // last two samples of the ready line
  logic [1:0] rdy_hist;
  logic       rdy_rise;

  assign cmd_hi   = cmd_data[7:4];
  assign is_read  = (cmd_hi == OP_MEM_READ_HI);
  assign is_write = (cmd_hi == OP_MEM_WRITE_HI);

  //////////////////////////////////////////////////
  // request pulses and write data
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcu_rrq <= 1'b0;
      mcu_wrq <= 1'b0;
    end else begin
      // a read is issued for the command byte too
      mcu_rrq <= (cmd_ready || param_ready) && is_read;
      mcu_wrq <= param_ready && is_write;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcu_data_out <= '0;
    end else if (param_ready && is_write) begin
      mcu_data_out <= param_data;
    end
  end

  //////////////////////////////////////////////////
  // ready edge
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_hist <= 2'b00;
    end else begin
      rdy_hist <= {rdy_hist[0], mcu_rq_rdy};
    end
  end

  assign rdy_rise = (rdy_hist == 2'b01);

  // read data is valid on the edge, response unit grabs it
  assign mem_data_capture = rdy_rise && is_read;

  //////////////////////////////////////////////////
  // address register
  //////////////////////////////////////////////////

  assign addr_load = param_ready && (cmd_hi == OP_ADDR_HI);

  // bit 3 enables auto-increment, bit 4 skips the command-byte access
  assign addr_incr = rdy_rise && (is_read || is_write) && cmd_data[3]
                     && (spi_byte_cnt >= CNT_CMD + byte_cnt_t'(cmd_data[4]));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr_out <= '0;
    end else if (addr_load) begin
      case (spi_byte_cnt)
        CNT_P1:  addr_out <= {param_data, 16'h0000};
        CNT_P2:  addr_out[15:8] <= param_data;
        CNT_P3:  addr_out[7:0] <= param_data;
        default: addr_out <= addr_out;
      endcase
    end else if (addr_incr) begin
      addr_out <= addr_out + 1'b1;
    end
  end

endmodule

// File: mcu_response.sv
`timescale 1ns/1ps

module mcu_response #(
  parameter cmd_proto_pkg::spi_byte_t SIG_BYTE = 8'hA5
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cmd_ready,
  input  logic                     param_ready,
  input  cmd_proto_pkg::spi_byte_t cmd_data,
  input  cmd_proto_pkg::spi_byte_t param_data,
  input  logic                     mem_data_capture,
  input  cmd_proto_pkg::spi_byte_t mcu_data_in,
  input  cmd_proto_pkg::spi_byte_t snescmd_data_in,
  output cmd_proto_pkg::spi_byte_t spi_data_out
);

  import cmd_proto_pkg::*;

  logic      link_strobe;
  logic      snescmd_rd;
  spi_byte_t resp_next;

  assign link_strobe = cmd_ready || param_ready;

  // command RAM reads, both the 0xAn group and read-next
  assign snescmd_rd = (cmd_data[7:4] == OP_SNESCMD_READ_HI)
                      || (cmd_data == OP_SNESCMD_READNEXT);

  //////////////////////////////////////////////////
  // next response byte
  //////////////////////////////////////////////////

  always_comb begin
    resp_next = spi_data_out;
    if (mem_data_capture) begin
      // memory read data wins over any strobe
      resp_next = mcu_data_in;
    end else if (link_strobe) begin
      if (snescmd_rd) begin
        resp_next = snescmd_data_in;
      end else begin
        case (cmd_data)
          OP_SIGNATURE: resp_next = SIG_BYTE;
          // loop back whatever came in
          OP_ECHO:      resp_next = param_data;
          default:      resp_next = spi_data_out;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // shifted out to the microcontroller on the next byte
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      spi_data_out <= '0;
    end else begin
      spi_data_out <= resp_next;
    end
  end

endmodule

// File: project.f
cmd_proto_pkg.sv
cart_mem_pkg.sv
cart_config_regs.sv
mcu_mem_access.sv
snescmd_port.sv
mcu_response.sv
mcu_cmd_top.sv
tb_mcu_cmd.sv

// File: snescmd_port.sv
`timescale 1ns/1ps

module snescmd_port #(
  parameter int SNESCMD_AW = 9
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     param_ready,
  input  cmd_proto_pkg::spi_byte_t cmd_data,
  input  cmd_proto_pkg::spi_byte_t param_data,
  input  cmd_proto_pkg::byte_cnt_t spi_byte_cnt,
  output logic [SNESCMD_AW-1:0]    snescmd_addr_out,
  output cmd_proto_pkg::spi_byte_t snescmd_data_out,
  output logic                     snescmd_we_out
);

  import cmd_proto_pkg::*;

  //////////////////////////////////////////////////
  // command RAM address
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      snescmd_addr_out <= '0;
    end else if (param_ready) begin
      case (cmd_data)
        OP_SNESCMD_SETADDR: begin
          // low byte first, then the upper bits
          if (spi_byte_cnt == CNT_P1) begin
            snescmd_addr_out[7:0] <= param_data;
          end else if (spi_byte_cnt == CNT_P2) begin
            snescmd_addr_out[SNESCMD_AW-1:8] <= param_data[SNESCMD_AW-9:0];
          end
        end
        // read-and-advance
        OP_SNESCMD_READNEXT: snescmd_addr_out <= snescmd_addr_out + 1'b1;
        OP_SNESCMD_WRITE: begin
          // step past the written location on the byte after the data
          if (spi_byte_cnt == CNT_P2) begin
            snescmd_addr_out <= snescmd_addr_out + 1'b1;
          end
        end
        default: snescmd_addr_out <= snescmd_addr_out;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // write data and strobe
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      snescmd_data_out <= '0;
      snescmd_we_out   <= 1'b0;
    end else begin
      snescmd_we_out <= param_ready && cmd_data == OP_SNESCMD_WRITE
                        && spi_byte_cnt == CNT_P1;
      if (param_ready && cmd_data == OP_SNESCMD_WRITE) begin
        snescmd_data_out <= param_data;
      end
    end
  end

endmodule

// File: tb_mcu_cmd.sv
`timescale 1ns/1ps

module tb_mcu_cmd;

  import cmd_proto_pkg::*;
  import cart_mem_pkg::*;

  localparam spi_byte_t SIG_VAL = 8'hA5;
  localparam int        CRAM_AW = 9;

  logic               clk;
  logic               arst_n;
  logic               cmd_ready;
  logic               param_ready;
  spi_byte_t          cmd_data;
  spi_byte_t          param_data;
  byte_cnt_t          spi_byte_cnt;
  spi_byte_t          spi_data_out;
  mapper_t            mcu_mapper;
  cart_mask_t         rom_mask_out;
  cart_mask_t         saveram_mask_out;
  feature_t           featurebits_out;
  logic               mcu_rrq;
  logic               mcu_wrq;
  logic               mcu_rq_rdy;
  spi_byte_t          mcu_data_out;
  spi_byte_t          mcu_data_in;
  cart_addr_t         addr_out;
  spi_byte_t          snescmd_data_in;
  logic [CRAM_AW-1:0] snescmd_addr_out;
  spi_byte_t          snescmd_data_out;
  logic               snescmd_we_out;

  integer             seed = 21645;
  int                 value_errs = 0;
  int                 other_errs = 0;
  logic [7:0]         cram [0:(1<<CRAM_AW)-1];
  logic               mem_busy;
  // expected state of the memory side
  logic               mem_chk = 1'b0;
  logic               exp_read = 1'b0;
  logic               exp_incr = 1'b0;
  cart_addr_t         exp_addr = '0;
  logic               rdy_prev = 1'b0;
  logic [1:0]         rise_sh = 2'b00;
  int                 rrq_cnt = 0;
  int                 wrq_cnt = 0;
  int                 we_cnt = 0;
  int                 edge_cnt = 0;
  logic [CRAM_AW-1:0] exp_cram_addr = '0;
  spi_byte_t          exp_cram_data = '0;

  mcu_cmd_top #(
    .SIG_BYTE   (SIG_VAL),
    .SNESCMD_AW (CRAM_AW)
  ) dut_i (.*);

  // read data follows the low address byte
  assign mcu_data_in     = addr_out[7:0] ^ 8'h5C;
  assign snescmd_data_in = cram[snescmd_addr_out];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errs++;
      $display("ERR %0d ns %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
    end
  endtask

  task automatic report_problem(input string msg);
    other_errs++;
    $display("%0d ns: %s", $time, msg);
  endtask

  assert property (@(posedge clk) disable iff (!arst_n) mcu_rrq |=> !mcu_rrq)
    else report_problem("mcu_rrq stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!arst_n) mcu_wrq |=> !mcu_wrq)
    else report_problem("mcu_wrq stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!arst_n) snescmd_we_out |=> !snescmd_we_out)
    else report_problem("snescmd_we_out stayed high for more than one cycle");

  // pulse counting and the per-edge memory compare
  always @(negedge clk) begin
    if (arst_n) begin
      if (mcu_rrq) rrq_cnt++;
      if (mcu_wrq) wrq_cnt++;
      if (snescmd_we_out) begin
        we_cnt++;
        check_val("snescmd_addr_out", exp_cram_addr, snescmd_addr_out);
        check_val("snescmd_data_out", exp_cram_data, snescmd_data_out);
      end
      // response and address settle two cycles after ready rises
      if (rise_sh[1] && mem_chk) begin
        if (exp_read) begin
          check_val("spi_data_out", exp_addr[7:0] ^ 8'h5C, spi_data_out);
        end
        if (exp_incr) begin
          exp_addr = exp_addr + 24'd1;
        end
        check_val("addr_out", exp_addr, addr_out);
        edge_cnt++;
      end
      rise_sh  = {rise_sh[0], mcu_rq_rdy && !rdy_prev};
      rdy_prev = mcu_rq_rdy;
    end
  end

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  initial begin : mem_model
    int delay;
    mcu_rq_rdy = 1'b0;
    mem_busy   = 1'b0;
    forever begin
      @(negedge clk);
      if (arst_n && (mcu_rrq || mcu_wrq)) begin
        mem_busy = 1'b1;
        delay = 1 + int'($unsigned($random(seed)) % 5);
        repeat (delay) @(posedge clk);
        #2 mcu_rq_rdy = 1'b1;
        repeat (4) @(posedge clk);
        #2 mcu_rq_rdy = 1'b0;
        mem_busy = 1'b0;
      end
    end
  end

  task automatic wait_mem_idle();
    int n;
    n = 0;
    while ((mem_busy || mcu_rq_rdy) && n < 40) begin
      @(posedge clk);
      n++;
    end
    if (n >= 40) begin
      report_problem("memory request did not complete within 40 cycles");
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // link stimulus
  //////////////////////////////////////////////////

  task automatic drive_byte(input logic is_cmd, input spi_byte_t b, input int cnt);
    @(posedge clk);
    #2;
    if (is_cmd) begin
      cmd_ready = 1'b1;
      cmd_data  = b;
    end else begin
      param_ready = 1'b1;
      param_data  = b;
    end
    spi_byte_cnt = byte_cnt_t'(cnt);
    @(posedge clk);
    #2;
    cmd_ready   = 1'b0;
    param_ready = 1'b0;
    // idle gap of three cycles
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic send_cmd(input spi_byte_t b);
    drive_byte(1'b1, b, 1);
  endtask

  task automatic send_param(input spi_byte_t b, input int cnt);
    drive_byte(1'b0, b, cnt);
  endtask

  task automatic load_mask(input spi_byte_t op, output cart_mask_t val);
    spi_byte_t r;
    int        k;
    send_cmd(op);
    val = '0;
    for (k = 0; k < 3; k++) begin
      r = spi_byte_t'($random(seed));
      send_param(r, k + 2);
      val = {val[15:0], r};
    end
  endtask

  initial begin : stimulus
    cart_mask_t rom_m;
    cart_mask_t sram_m;
    spi_byte_t  b0;
    spi_byte_t  b1;
    int         k;
    for (k = 0; k < (1 << CRAM_AW); k++) begin
      cram[k] = 8'((k * 37) ^ (k >> 3));
    end
    arst_n       = 1'b0;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = '0;
    param_data   = '0;
    spi_byte_cnt = '0;
    repeat (16) begin
      @(negedge clk);
      check_val("mcu_rrq", 0, mcu_rrq);
      check_val("mcu_wrq", 0, mcu_wrq);
      check_val("snescmd_we_out", 0, snescmd_we_out);
    end
    check_val("spi_data_out", 0, spi_data_out);
    check_val("mcu_mapper", 0, mcu_mapper);
    check_val("mcu_data_out", 0, mcu_data_out);
    check_val("addr_out", 0, addr_out);
    check_val("rom_mask_out", 0, rom_mask_out);
    check_val("saveram_mask_out", 0, saveram_mask_out);
    check_val("featurebits_out", 0, featurebits_out);
    check_val("snescmd_addr_out", 0, snescmd_addr_out);
    check_val("snescmd_data_out", 0, snescmd_data_out);
    @(posedge clk);
    #2 arst_n = 1'b1;
    repeat (2) @(negedge clk);

    // configuration registers
    send_cmd(8'h35);
    check_val("mcu_mapper", 5, mcu_mapper);
    load_mask(8'h10, rom_m);
    check_val("rom_mask_out", rom_m, rom_mask_out);
    load_mask(8'h20, sram_m);
    check_val("saveram_mask_out", sram_m, saveram_mask_out);
    check_val("rom_mask_out", rom_m, rom_mask_out);
    b0 = spi_byte_t'($random(seed));
    b1 = spi_byte_t'($random(seed));
    send_cmd(8'hED);
    send_param(b0, 2);
    send_param(b1, 3);
    check_val("featurebits_out", {b0, b1}, featurebits_out);

    // signature and echo
    send_cmd(8'hF0);
    send_param(8'h00, 2);
    check_val("spi_data_out", SIG_VAL, spi_data_out);
    b0 = spi_byte_t'($random(seed));
    send_cmd(8'hFF);
    send_param(b0, 2);
    check_val("spi_data_out", b0, spi_data_out);

    // address load, top byte first
    send_cmd(8'h00);
    send_param(8'h12, 2);
    check_val("addr_out", 24'h120000, addr_out);
    send_param(8'h34, 3);
    check_val("addr_out", 24'h123400, addr_out);
    send_param(8'hFE, 4);
    check_val("addr_out", 24'h1234FE, addr_out);

    // reads with auto-increment, command byte reads too
    exp_addr = 24'h1234FE;
    exp_read = 1'b1;
    exp_incr = 1'b1;
    mem_chk  = 1'b1;
    rrq_cnt  = 0;
    edge_cnt = 0;
    send_cmd(8'h88);
    wait_mem_idle();
    for (k = 0; k < 3; k++) begin
      send_param(spi_byte_t'($random(seed)), k + 2);
      wait_mem_idle();
    end
    check_val("mcu_rrq pulse count", 4, rrq_cnt);
    check_val("ready edge count", 4, edge_cnt);
    check_val("addr_out", 24'h123502, addr_out);

    // reads with the address held
    exp_incr = 1'b0;
    rrq_cnt  = 0;
    send_cmd(8'h80);
    wait_mem_idle();
    for (k = 0; k < 2; k++) begin
      send_param(spi_byte_t'($random(seed)), k + 2);
      wait_mem_idle();
    end
    check_val("mcu_rrq pulse count", 3, rrq_cnt);
    check_val("addr_out", 24'h123502, addr_out);

    // writes with auto-increment
    exp_read = 1'b0;
    exp_incr = 1'b1;
    wrq_cnt  = 0;
    edge_cnt = 0;
    send_cmd(8'h98);
    for (k = 0; k < 3; k++) begin
      b0 = spi_byte_t'($random(seed));
      send_param(b0, k + 2);
      check_val("mcu_data_out", b0, mcu_data_out);
      wait_mem_idle();
    end
    check_val("mcu_wrq pulse count", 3, wrq_cnt);
    check_val("ready edge count", 3, edge_cnt);
    check_val("addr_out", 24'h123505, addr_out);
    mem_chk = 1'b0;

    // command RAM port
    send_cmd(8'hD0);
    send_param(8'h34, 2);
    send_param(8'h01, 3);
    check_val("snescmd_addr_out", 9'h134, snescmd_addr_out);
    exp_cram_addr = 9'h134;
    exp_cram_data = spi_byte_t'($random(seed));
    we_cnt = 0;
    send_cmd(8'hD2);
    send_param(exp_cram_data, 2);
    send_param(spi_byte_t'($random(seed)), 3);
    check_val("snescmd_we_out pulse count", 1, we_cnt);
    check_val("snescmd_addr_out", 9'h135, snescmd_addr_out);
    send_cmd(8'hD1);
    send_param(8'h00, 2);
    check_val("spi_data_out", cram[9'h135], spi_data_out);
    check_val("snescmd_addr_out", 9'h136, snescmd_addr_out);

    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
